// File: board_status_top.f
+incdir+logic
+incdir+tb
logic/display_pkg.sv
logic/status_pkg.sv
logic/scan_sequencer.sv
logic/byte_history_hex.sv
logic/load_banner.sv
logic/seg_driver.sv
logic/status_rgb_led.sv
logic/board_status_top.sv
tb/tb_board_status.sv

// File: Makefile
# Verilator build and run of the board status testbench

TOP := tb_board_status

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f board_status_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb/tb_checks.svh
// glyph tables, led model, failure report and typed compare tasks for the board status testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// a in bit 6 down to g in bit 0, dp in bit 7
localparam display_pkg::segment_t HEX_TAB [16] = '{
    8'h7e, 8'h30, 8'h6d, 8'h79, 8'h33, 8'h5b, 8'h5f, 8'h70,
    8'h7f, 8'h7b, 8'h77, 8'h1f, 8'h4e, 8'h3d, 8'h4f, 8'h47};

// blanks, L o a d i n g, two dots
localparam display_pkg::segment_t LOAD_TAB [16] = '{
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h0e,
    8'h1d, 8'h7d, 8'h3d, 8'h10, 8'h15, 8'hfb, 8'h80, 8'h80};

// by digit, "ArchProc" read from digit 7 down
localparam display_pkg::segment_t BOOT_TAB [8] = '{
    8'h0d, 8'h1d, 8'h05, 8'h67, 8'h17, 8'h0d, 8'h05, 8'h77};

// blink and colour rule, breathing bits win
function automatic status_pkg::rgb_t led_expect(input logic breathe, input logic done,
                                                input status_pkg::priv_t lvl,
                                                input int blink,
                                                input status_pkg::rgb_t breath);
    status_pkg::rgb_t rgb;
    if (breathe) begin
        rgb = breath;
    end else if (!done || blink != 0) begin
        rgb = 3'b000;
    end else begin
        case (lvl)
            2'd0:    rgb = 3'b001;   // U red
            2'd1:    rgb = 3'b010;   // S green
            2'd3:    rgb = 3'b100;   // M blue
            default: rgb = 3'b000;
        endcase
    end
    return rgb;
endfunction

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
endtask

task automatic check_segment(input string name, input display_pkg::segment_t got,
                             input display_pkg::segment_t exp);
    if (got !== exp) begin
        fail_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic check_anode(input string name, input display_pkg::anode_t got,
                           input display_pkg::anode_t exp);
    if (got !== exp) begin
        fail_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
    end
endtask

task automatic check_rgb(input string name, input status_pkg::rgb_t got,
                         input status_pkg::rgb_t exp);
    if (got !== exp) begin
        fail_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
    end
endtask

`endif

// File: tb/tb_board_status.sv
// board status testbench: clock, reset, random stimulus, cycle model, watchdog, test sequence
`timescale 1ns/1ps
`include "board_status_defines.svh"

module tb_board_status;

    localparam int SCAN_DIV    = 6;
    localparam int SCROLL_BITS = 3;
    localparam int RST_CYC     = 4;
    localparam int HEX_CYC     = 400;
    localparam int LOAD_CYC    = 300;
    localparam int BREATHE_CYC = 9000;
    localparam int TOTAL_CYC   = RST_CYC + HEX_CYC + LOAD_CYC + BREATHE_CYC;
    localparam int STEP_B [3]  = '{`PHASE_STEP_R, `PHASE_STEP_G, `PHASE_STEP_B};
    localparam int START_B [3] = '{`PHASE_START_R, `PHASE_START_G, `PHASE_START_B};

    logic                  core_clk = 1'b0;
    logic                  core_rst_x;
    logic                  kbd_we;
    status_pkg::ps2_byte_t kbd_data;
    logic                  mouse_we;
    status_pkg::ps2_byte_t mouse_data;
    logic                  blank_btn;
    logic                  load;
    logic                  init_done;
    status_pkg::priv_t     priv;
    logic                  breathe_mode;
    display_pkg::segment_t seg_n;
    display_pkg::anode_t   an_n;
    logic                  led_r;
    logic                  led_g;
    logic                  led_b;

    integer seed = 32'hb180_37b9;

    // model state
    int                      m_div = 0;
    display_pkg::digit_idx_t m_digit = '0;
    display_pkg::anode_t     m_anode = '1;
    display_pkg::disp_word_t m_hist = '0;
    int                      m_pre = 0;
    int                      m_scroll = 0;
    display_pkg::segment_t   m_hex;
    display_pkg::segment_t   m_load;
    display_pkg::segment_t   m_boot;
    display_pkg::segment_t   m_seg;
    display_pkg::anode_t     m_an = '1;
    int                      m_pwm = 0;
    int                      m_blink = 0;
    int                      m_phase [3] = '{0, 0, 0};
    status_pkg::rgb_t        m_breath;
    int                      edges = 0;
    display_pkg::anode_t     last_an = '1;
    int                      win_len = 0;
    bit                      win_armed = 1'b0;

    `include "tb_checks.svh"

    board_status_top #(
        .SCAN_DIV    (SCAN_DIV),
        .SCROLL_BITS (SCROLL_BITS)
    ) dut_i (
        .core_clk     (core_clk),
        .core_rst_x   (core_rst_x),
        .kbd_we       (kbd_we),
        .kbd_data     (kbd_data),
        .mouse_we     (mouse_we),
        .mouse_data   (mouse_data),
        .blank_btn    (blank_btn),
        .load         (load),
        .init_done    (init_done),
        .priv         (priv),
        .breathe_mode (breathe_mode),
        .seg_n        (seg_n),
        .an_n         (an_n),
        .led_r        (led_r),
        .led_g        (led_g),
        .led_b        (led_b)
    );

    always #4 core_clk = ~core_clk;

    // one model cycle from pre-edge values with the counters updated last
    always @(posedge core_clk) begin
        display_pkg::disp_word_t word;
        int                      low;
        edges++;
        if (load) begin
            m_seg = ~m_load;
        end else if (core_rst_x) begin
            m_seg = ~m_hex;
        end else begin
            m_seg = ~m_boot;
        end
        m_an = core_rst_x ? m_anode : '1;
        if (m_div == 0) begin   // scan tick
            word   = blank_btn ? '0 : m_hist;
            m_hex  = HEX_TAB[display_pkg::nibble_t'(word >> (4 * m_digit))];
            m_load = LOAD_TAB[display_pkg::scroll_idx_t'(m_scroll + 7 - int'(m_digit))];
            m_boot = BOOT_TAB[m_digit];
        end
        for (int i = 0; i < 3; i++) begin
            low = m_phase[i] % 4096;
            m_breath[i] = (m_phase[i] >= 4096) ? (low < m_pwm) : (low >= m_pwm);
        end
        if (!core_rst_x) begin
            m_div    = 0;
            m_digit  = '0;
            m_anode  = 8'hfe;
            m_hist   = '0;
            m_pre    = 0;
            m_scroll = 0;
            m_pwm    = 0;
            m_blink  = 1;
            m_phase  = START_B;
        end else begin
            if (m_div == 0) begin
                m_anode = ~(8'h01 << m_digit);
                m_digit = m_digit + 1'b1;   // wraps after 7
            end
            m_div = (m_div + 1) % SCAN_DIV;
            if (kbd_we) begin
                m_hist[15:0] = {m_hist[7:0], kbd_data};
            end
            if (mouse_we) begin
                m_hist[31:16] = {m_hist[23:16], mouse_data};
            end
            if (load) begin
                if (m_pre == 0) begin
                    m_scroll = (m_scroll + 1) % 16;
                end
                m_pre = (m_pre + 1) % (1 << SCROLL_BITS);
            end
            if (m_pwm == 0) begin
                for (int i = 0; i < 3; i++) begin
                    m_phase[i] = (m_phase[i] + STEP_B[i]) % 8192;
                end
            end
            m_pwm   = (m_pwm + 1) % 4096;
            m_blink = (m_blink + 1) % 16;
        end
    end

    // outputs settled at the falling edge
    always @(negedge core_clk) begin
        if (edges >= 3) begin
            check_segment("seg_n", seg_n, m_seg);
            check_anode("an_n", an_n, m_an);
            check_rgb("led_bgr", {led_b, led_g, led_r},
                      led_expect(breathe_mode, init_done, priv, m_blink, m_breath));
            if (an_n != '1 && !$onehot(~an_n)) begin
                fail_run($sformatf("an_n %b lights more or less than one digit", an_n));
            end
            if (an_n != last_an) begin
                if (win_armed && win_len != SCAN_DIV) begin
                    fail_run($sformatf("digit window lasted %0d cycles instead of %0d",
                                       win_len, SCAN_DIV));
                end
                win_armed = (last_an != '1);   // skip the window out of reset
                win_len   = 1;
                last_an   = an_n;
            end else begin
                win_len++;
            end
        end
    end

    task automatic drive_random();
        kbd_we     <= ($random(seed) & 3) == 0;
        kbd_data   <= status_pkg::ps2_byte_t'($random(seed));
        mouse_we   <= ($random(seed) & 7) == 0;
        mouse_data <= status_pkg::ps2_byte_t'($random(seed));
        priv       <= status_pkg::priv_t'($random(seed));
        if (($random(seed) & 31) == 0) begin
            blank_btn <= ~blank_btn;
        end
        if (($random(seed) & 15) == 0) begin
            init_done <= ~init_done;
        end
    endtask

    initial begin
        #(TOTAL_CYC * 12);   // 1.5 times the whole sequence
        fail_run("timeout: test sequence did not finish");
    end

    initial begin
        core_rst_x   = 1'b0;
        kbd_we       = 1'b0;
        kbd_data     = '0;
        mouse_we     = 1'b0;
        mouse_data   = '0;
        blank_btn    = 1'b0;
        load         = 1'b0;
        init_done    = 1'b0;
        priv         = '0;
        breathe_mode = 1'b0;
        repeat (RST_CYC) @(posedge core_clk);
        core_rst_x <= 1'b1;
        repeat (HEX_CYC) begin   // hex display and privilege blink
            @(posedge core_clk);
            drive_random();
        end
        load <= 1'b1;
        repeat (LOAD_CYC) begin
            @(posedge core_clk);
            drive_random();
        end
        @(posedge core_clk);
        load         <= 1'b0;
        breathe_mode <= 1'b1;
        repeat (BREATHE_CYC) begin
            @(posedge core_clk);
            drive_random();
        end
        @(posedge core_clk);
        @(negedge core_clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: logic/board_status_top.sv
// board status front end: digit scan, hex and banner paths, segment driver, rgb led
`timescale 1ns/1ps
`include "board_status_defines.svh"

module board_status_top #(
    parameter int SCAN_DIV    = `SEG_SCAN_DIV_DEF,
    parameter int SCROLL_BITS = `LOAD_SCROLL_BITS_DEF
) (
    input  logic                  core_clk,
    input  logic                  core_rst_x,
    input  logic                  kbd_we,
    input  status_pkg::ps2_byte_t kbd_data,
    input  logic                  mouse_we,
    input  status_pkg::ps2_byte_t mouse_data,
    input  logic                  blank_btn,
    input  logic                  load,
    input  logic                  init_done,
    input  status_pkg::priv_t     priv,
    input  logic                  breathe_mode,
    output display_pkg::segment_t seg_n,
    output display_pkg::anode_t   an_n,
    output logic                  led_r,
    output logic                  led_g,
    output logic                  led_b
);

    logic                    scan_tick;
    display_pkg::digit_idx_t digit;
    display_pkg::anode_t     anode;
    display_pkg::segment_t   hex_glyph;
    display_pkg::segment_t   load_glyph;
    display_pkg::segment_t   boot_glyph;

    scan_sequencer #(
        .SCAN_DIV   (SCAN_DIV)
    ) scan_i (
        .core_clk   (core_clk),
        .core_rst_x (core_rst_x),
        .scan_tick  (scan_tick),
        .digit      (digit),
        .anode      (anode)
    );

    byte_history_hex hex_i (
        .core_clk   (core_clk),
        .core_rst_x (core_rst_x),
        .kbd_we     (kbd_we),
        .kbd_data   (kbd_data),
        .mouse_we   (mouse_we),
        .mouse_data (mouse_data),
        .blank_btn  (blank_btn),
        .scan_tick  (scan_tick),
        .digit      (digit),
        .hex_glyph  (hex_glyph)
    );

    load_banner #(
        .SCROLL_BITS (SCROLL_BITS)
    ) banner_i (
        .core_clk   (core_clk),
        .core_rst_x (core_rst_x),
        .load       (load),
        .scan_tick  (scan_tick),
        .digit      (digit),
        .load_glyph (load_glyph),
        .boot_glyph (boot_glyph)
    );

    seg_driver seg_i (
        .core_clk   (core_clk),
        .core_rst_x (core_rst_x),
        .load       (load),
        .anode      (anode),
        .hex_glyph  (hex_glyph),
        .load_glyph (load_glyph),
        .boot_glyph (boot_glyph),
        .seg_n      (seg_n),
        .an_n       (an_n)
    );

    status_rgb_led rgb_i (
        .core_clk     (core_clk),
        .core_rst_x   (core_rst_x),
        .breathe_mode (breathe_mode),
        .init_done    (init_done),
        .priv         (priv),
        .led_r        (led_r),
        .led_g        (led_g),
        .led_b        (led_b)
    );

endmodule

// File: logic/status_rgb_led.sv
// rgb status led: breathing pwm phases and privilege colour blink
`timescale 1ns/1ps
`include "board_status_defines.svh"

module status_rgb_led (
    input  logic              core_clk,
    input  logic              core_rst_x,
    input  logic              breathe_mode,
    input  logic              init_done,
    input  status_pkg::priv_t priv,
    output logic              led_r,
    output logic              led_g,
    output logic              led_b
);

    localparam int PHASE_W = `PWM_BITS + 1;   // top bit flips the compare direction

    // indexed like rgb_t: 0 red, 1 green, 2 blue
    localparam logic [PHASE_W-1:0] PHASE_START [3] = '{
        PHASE_W'(`PHASE_START_R), PHASE_W'(`PHASE_START_G), PHASE_W'(`PHASE_START_B)};
    localparam logic [PHASE_W-1:0] PHASE_STEP [3] = '{
        PHASE_W'(`PHASE_STEP_R), PHASE_W'(`PHASE_STEP_G), PHASE_W'(`PHASE_STEP_B)};

    // nonzero start keeps the colour dark through reset
    localparam logic [`BLINK_BITS-1:0] BLINK_START = 1;

    logic [`PWM_BITS-1:0]   pwm_cnt;
    logic [`BLINK_BITS-1:0] blink_cnt;
    logic [PHASE_W-1:0]     phase [3];
    status_pkg::rgb_t       breath_rgb;
    status_pkg::rgb_t       led_rgb;

    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            pwm_cnt   <= '0;
            blink_cnt <= BLINK_START;
            for (int i = 0; i < 3; i++) begin
                phase[i] <= PHASE_START[i];
            end
        end else begin
            pwm_cnt   <= pwm_cnt + 1'b1;
            blink_cnt <= blink_cnt + 1'b1;
            for (int i = 0; i < 3; i++) begin
                if (pwm_cnt == '0) begin
                    phase[i] <= phase[i] + PHASE_STEP[i];   // once per pwm period
                end
            end
        end
    end

    // duty ramps up then down as the phase wraps
    always_ff @(posedge core_clk) begin
        for (int i = 0; i < 3; i++) begin
            breath_rgb[i] <= phase[i][PHASE_W-1] ? (phase[i][PHASE_W-2:0] <  pwm_cnt)
                                                 : (phase[i][PHASE_W-2:0] >= pwm_cnt);
        end
    end

    always_comb begin
        if (breathe_mode) begin
            led_rgb = breath_rgb;
        end else if (!init_done || blink_cnt != '0) begin
            led_rgb = '0;
        end else begin
            case (priv)
                status_pkg::PRIV_U: led_rgb = 3'b001;   // red
                status_pkg::PRIV_S: led_rgb = 3'b010;   // green
                status_pkg::PRIV_M: led_rgb = 3'b100;   // blue
                default:            led_rgb = '0;
            endcase
        end
    end

    assign led_r = led_rgb[0];
    assign led_g = led_rgb[1];
    assign led_b = led_rgb[2];

endmodule

// File: logic/seg_driver.sv
// segment source select and registered active-low segment and anode outputs
`timescale 1ns/1ps

module seg_driver (
    input  logic                  core_clk,
    input  logic                  core_rst_x,
    input  logic                  load,
    input  display_pkg::anode_t   anode,
    input  display_pkg::segment_t hex_glyph,
    input  display_pkg::segment_t load_glyph,
    input  display_pkg::segment_t boot_glyph,
    output display_pkg::segment_t seg_n,
    output display_pkg::anode_t   an_n
);

    display_pkg::segment_t glyph_sel;

    // loading banner wins even in reset, boot banner only in reset
    always_comb begin
        if (load) begin
            glyph_sel = load_glyph;
        end else if (core_rst_x) begin
            glyph_sel = hex_glyph;
        end else begin
            glyph_sel = boot_glyph;
        end
    end

    always_ff @(posedge core_clk) begin
        seg_n <= ~glyph_sel;   // cathodes are active low
    end

    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            an_n <= '1;   // all digits dark
        end else begin
            an_n <= anode;
        end
    end

    // hex and boot glyphs never light all eight segments
    a_seg_not_all_lit: assert property (@(posedge core_clk) disable iff (!core_rst_x)
        !load |=> seg_n != '0);

endmodule

// File: logic/load_banner.sv
// load scroll prescaler and position, loading and boot banner glyph tables
`timescale 1ns/1ps
`include "board_status_defines.svh"

module load_banner #(
    parameter int SCROLL_BITS = `LOAD_SCROLL_BITS_DEF
) (
    input  logic                    core_clk,
    input  logic                    core_rst_x,
    input  logic                    load,
    input  logic                    scan_tick,
    input  display_pkg::digit_idx_t digit,
    output display_pkg::segment_t   load_glyph,
    output display_pkg::segment_t   boot_glyph
);

    localparam display_pkg::segment_t SEG_BLANK = 8'b0000_0000;
    localparam display_pkg::segment_t SEG_DP    = 8'b1000_0000;

    logic [SCROLL_BITS-1:0]   prescale;
    display_pkg::scroll_idx_t scroll;
    display_pkg::scroll_idx_t load_idx;

    // seven blanks, "Loading", two dots
    function automatic display_pkg::segment_t load_seg(input display_pkg::scroll_idx_t idx);
        display_pkg::segment_t seg;
        case (idx)
            4'd7:    seg = 8'b0000_1110;   // L
            4'd8:    seg = 8'b0001_1101;   // o
            4'd9:    seg = 8'b0111_1101;   // a
            4'd10:   seg = 8'b0011_1101;   // d
            4'd11:   seg = 8'b0001_0000;   // i
            4'd12:   seg = 8'b0001_0101;   // n
            4'd13:   seg = 8'b1111_1011;   // g, with its dot
            4'd14,
            4'd15:   seg = SEG_DP;
            default: seg = SEG_BLANK;
        endcase
        return seg;
    endfunction

    // "ArchProc", digit 7 holds the A
    function automatic display_pkg::segment_t boot_seg(input display_pkg::digit_idx_t d);
        display_pkg::segment_t seg;
        case (d)
            3'd7:    seg = 8'b0111_0111;   // A
            3'd6,
            3'd2:    seg = 8'b0000_0101;   // r
            3'd4:    seg = 8'b0001_0111;   // h
            3'd3:    seg = 8'b0110_0111;   // P
            3'd1:    seg = 8'b0001_1101;   // o
            default: seg = 8'b0000_1101;   // c on digits 5 and 0
        endcase
        return seg;
    endfunction

    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            prescale <= '0;
            scroll   <= '0;
        end else if (load) begin
            prescale <= prescale + 1'b1;
            if (prescale == '0) begin
                scroll <= scroll + 1'b1;   // text moves one digit left
            end
        end
    end

    // wraps modulo 16
    assign load_idx = scroll + display_pkg::scroll_idx_t'(7) - display_pkg::scroll_idx_t'(digit);

    always_ff @(posedge core_clk) begin
        if (scan_tick) begin
            load_glyph <= load_seg(load_idx);
            boot_glyph <= boot_seg(digit);
        end
    end

endmodule

// File: logic/byte_history_hex.sv
// keyboard and mouse byte history, blank button, nibble select and hex glyph decode
`timescale 1ns/1ps

module byte_history_hex (
    input  logic                    core_clk,
    input  logic                    core_rst_x,
    input  logic                    kbd_we,
    input  status_pkg::ps2_byte_t   kbd_data,
    input  logic                    mouse_we,
    input  status_pkg::ps2_byte_t   mouse_data,
    input  logic                    blank_btn,
    input  logic                    scan_tick,
    input  display_pkg::digit_idx_t digit,
    output display_pkg::segment_t   hex_glyph
);

    display_pkg::disp_word_t history;     // {mouse old, mouse new, kbd old, kbd new}
    display_pkg::disp_word_t shown_word;
    display_pkg::nibble_t    nibble;

    // standard a-g hex font, dp off
    function automatic display_pkg::segment_t hex_seg(input display_pkg::nibble_t value);
        display_pkg::segment_t seg;
        case (value)
            4'h0:    seg = 8'b0111_1110;
            4'h1:    seg = 8'b0011_0000;
            4'h2:    seg = 8'b0110_1101;
            4'h3:    seg = 8'b0111_1001;
            4'h4:    seg = 8'b0011_0011;
            4'h5:    seg = 8'b0101_1011;
            4'h6:    seg = 8'b0101_1111;
            4'h7:    seg = 8'b0111_0000;
            4'h8:    seg = 8'b0111_1111;
            4'h9:    seg = 8'b0111_1011;
            4'ha:    seg = 8'b0111_0111;
            4'hb:    seg = 8'b0001_1111;
            4'hc:    seg = 8'b0100_1110;
            4'hd:    seg = 8'b0011_1101;
            4'he:    seg = 8'b0100_1111;
            default: seg = 8'b0100_0111;   // f
        endcase
        return seg;
    endfunction

    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            history <= '0;
        end else begin
            if (kbd_we) begin
                history[7:0]  <= kbd_data;
                history[15:8] <= history[7:0];
            end
            if (mouse_we) begin
                history[23:16] <= mouse_data;
                history[31:24] <= history[23:16];
            end
        end
    end

    assign shown_word = blank_btn ? '0 : history;
    assign nibble     = shown_word[{digit, 2'b00} +: 4];   // digit 0 is bits 3:0

    always_ff @(posedge core_clk) begin
        if (scan_tick) begin
            hex_glyph <= hex_seg(nibble);
        end
    end

endmodule

// File: logic/scan_sequencer.sv
// digit dwell divider, digit counter and one-cold anode register
`timescale 1ns/1ps
`include "board_status_defines.svh"

module scan_sequencer #(
    parameter int SCAN_DIV = `SEG_SCAN_DIV_DEF
) (
    input  logic                    core_clk,
    input  logic                    core_rst_x,
    output logic                    scan_tick,
    output display_pkg::digit_idx_t digit,
    output display_pkg::anode_t     anode
);

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam display_pkg::digit_idx_t LAST_DIGIT = display_pkg::digit_idx_t'(`SEG_DIGITS - 1);

    logic [DIV_W-1:0] div_cnt;

    assign scan_tick = (div_cnt == '0);   // also high all through reset

    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            div_cnt <= '0;
        end else if (div_cnt == DIV_W'(SCAN_DIV - 1)) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // anode trails digit by one tick like the glyph registers in the paths
    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            digit <= '0;
            anode <= ~display_pkg::anode_t'(1);
        end else if (scan_tick) begin
            digit <= (digit == LAST_DIGIT) ? '0 : digit + 1'b1;
            anode <= ~(display_pkg::anode_t'(1) << digit);   // old digit value
        end
    end

    a_anode_one_cold: assert property (@(posedge core_clk) disable iff (!core_rst_x)
        $onehot(~anode));

endmodule

// File: logic/status_pkg.sv
// status types: privilege level and its codes, ps/2 byte, rgb triple
package status_pkg;

    typedef logic [1:0] priv_t;

    localparam priv_t PRIV_U = 2'd0;   // user
    localparam priv_t PRIV_S = 2'd1;   // supervisor
    localparam priv_t PRIV_M = 2'd3;   // machine

    typedef logic [7:0] ps2_byte_t;

    // bit 2 blue, bit 1 green, bit 0 red
    typedef logic [2:0] rgb_t;

endpackage

// File: logic/display_pkg.sv
// display types: segment pattern, anode vector, digit index, nibble, shown word, scroll index
`include "board_status_defines.svh"

package display_pkg;

    // bit 7 is the decimal point, bits 6:0 are segments a to g, 1 = lit
    typedef logic [7:0] segment_t;

    // one-cold digit enables, a zero lights that digit
    typedef logic [`SEG_DIGITS-1:0] anode_t;

    typedef logic [$clog2(`SEG_DIGITS)-1:0] digit_idx_t;   // digit 0 is the rightmost

    typedef logic [3:0] nibble_t;

    // four bits per digit
    typedef logic [4*`SEG_DIGITS-1:0] disp_word_t;

    typedef logic [3:0] scroll_idx_t;   // position in the 16-entry banner table

endpackage

// File: logic/board_status_defines.svh
// display scan and scroll divider defaults, digit count, rgb pwm and breathing phase constants
`ifndef BOARD_STATUS_DEFINES_SVH
`define BOARD_STATUS_DEFINES_SVH

// seven-segment scan
`define SEG_SCAN_DIV_DEF      16000   // cycles per digit, about 1 ms at 16 MHz
`define LOAD_SCROLL_BITS_DEF  25      // banner steps once per 2^25 cycles
`define SEG_DIGITS            8

// rgb led
`define PWM_BITS              12
`define BLINK_BITS            4       // colour lit one cycle in 16

// breathing phase counters, one per colour
`define PHASE_START_B         0
`define PHASE_START_G         64
`define PHASE_START_R         512

// phase advance per pwm period
`define PHASE_STEP_B          2
`define PHASE_STEP_G          3
`define PHASE_STEP_R          5

`endif
